/* shadow_map_pkg.sv */
/* shadow memory map
   bank sizes and the decode of the 64 KB dump window */
package shadow_map_pkg;

    // word address widths of the four banks
    localparam int VRAM_AW = 14;            // 16k words, 32 KB
    localparam int CHAR_AW = 11;            // 2k words
    localparam int PAL_AW  = 11;            // 2k words
    localparam int OBJ_AW  = 10;            // 1k words

    // address carried between stages, sized for vram
    localparam int ADDR_W  = 14;

    // dump side byte address
    localparam int DUMP_W  = 16;

    // region select field of the dump address
    localparam int SEL_HI  = 15;
    localparam int SEL_LO  = 11;
    localparam int SEL_W   = SEL_HI - SEL_LO + 1;

    // mask and match pairs on dump bits 15..11
    localparam logic [SEL_W-1:0] VRAM_MASK  = 5'b10000;  // 0xxxx
    localparam logic [SEL_W-1:0] VRAM_MATCH = 5'b00000;
    localparam logic [SEL_W-1:0] CHAR_MASK  = 5'b11110;  // 1000x
    localparam logic [SEL_W-1:0] CHAR_MATCH = 5'b10000;
    localparam logic [SEL_W-1:0] PAL_MASK   = 5'b11110;  // 1001x
    localparam logic [SEL_W-1:0] PAL_MATCH  = 5'b10010;
    localparam logic [SEL_W-1:0] OBJ_MASK   = 5'b11111;  // 10100 only
    localparam logic [SEL_W-1:0] OBJ_MATCH  = 5'b10100;

    // anything else reads back as zero

    // dump address loaded at reset, falls in the unmapped area
    localparam logic [DUMP_W-1:0] DUMP_IDLE = 16'hffff;

endpackage

/* shadow_bus_pkg.sv */
/* shadow bus types
   data word, byte write mask and region code shared by all stages */
package shadow_bus_pkg;

    localparam int BYTE_W = 8;
    localparam int NBYTES = 2;              // bytes per bank word

    // one word of every bank and of the cpu bus
    typedef logic [NBYTES*BYTE_W-1:0] word_t;

    // byte write enable, bit 1 is the high byte, active high
    typedef logic [NBYTES-1:0] mask_t;

    // which bank a write or a dump read goes to
    typedef enum logic [2:0] {
        region_none   = 3'd0,
        region_vram   = 3'd1,
        region_char   = 3'd2,
        region_pal    = 3'd3,
        region_objram = 3'd4
    } region_e;

endpackage

/* shadow_if.sv */
/* shadow stage links
   write link from capture to store, read link from dump to store */
`timescale 1ns/1ps

interface shadow_wr_if;
    shadow_bus_pkg::region_e            region;  // none when no chip select
    logic [shadow_map_pkg::ADDR_W-1:0]  addr;    // word address, widest bank
    shadow_bus_pkg::word_t              data;
    shadow_bus_pkg::mask_t              we;      // nonzero means a write

    modport capture (
        output region,
        output addr,
        output data,
        output we
    );

    modport store (
        input  region,
        input  addr,
        input  data,
        input  we
    );
endinterface

interface shadow_rd_if;
    shadow_bus_pkg::region_e            region;  // bank to read
    logic [shadow_map_pkg::ADDR_W-1:0]  addr;
    shadow_bus_pkg::word_t              q;       // one cycle after region/addr

    modport dump (
        output region,
        output addr,
        input  q
    );

    modport store (
        input  region,
        input  addr,
        output q
    );
endinterface

/* shadow_capture.sv */
/* shadow write capture
   registers the cpu bus and folds the four chip selects into a region code */
`timescale 1ns/1ps

module shadow_capture (
    input  logic                             clk_rom,
    input  logic                             rst_n,
    input  logic [shadow_map_pkg::ADDR_W:1]  addr,       // cpu word address
    input  logic                             char_cs,
    input  logic                             vram_cs,
    input  logic                             pal_cs,
    input  logic                             objram_cs,
    input  shadow_bus_pkg::word_t            din,
    input  shadow_bus_pkg::mask_t            dswn,       // active low
    shadow_wr_if.capture                     wr
);

    shadow_bus_pkg::region_e region_d;
    shadow_bus_pkg::mask_t   we_d;

    // chip select to region with at most one set
    always_comb begin
        case (1'b1)
            vram_cs:   region_d = shadow_bus_pkg::region_vram;
            char_cs:   region_d = shadow_bus_pkg::region_char;
            pal_cs:    region_d = shadow_bus_pkg::region_pal;
            objram_cs: region_d = shadow_bus_pkg::region_objram;
            default:   region_d = shadow_bus_pkg::region_none;
        endcase
    end

    // active high mask and no write without a select
    assign we_d = (region_d == shadow_bus_pkg::region_none) ? '0 : ~dswn;

    // control side cleared so nothing is written after reset
    always_ff @(posedge clk_rom or negedge rst_n) begin
        if (!rst_n) begin
            wr.region <= shadow_bus_pkg::region_none;
            wr.we     <= '0;
        end else begin
            wr.region <= region_d;
            wr.we     <= we_d;
        end
    end

    // payload only matters while we is set
    always_ff @(posedge clk_rom) begin
        wr.addr <= addr;
        wr.data <= din;                  // bank write one edge later
    end

    // the cpu decoder never selects two work memories at once
    a_one_cs: assert property (
        @(posedge clk_rom) disable iff (!rst_n)
        $onehot0({vram_cs, char_cs, pal_cs, objram_cs})
    ) else $error("shadow_capture: more than one chip select active");

endmodule

/* shadow_bank.sv */
/* shadow bank
   dual port word memory, byte masked write port and registered read port */
`timescale 1ns/1ps

module shadow_bank #(
    parameter int aw = 10                            // word address width
) (
    input  logic                    clk_rom,
    input  shadow_bus_pkg::mask_t   we,              // per byte active high
    input  logic [aw-1:0]           waddr,
    input  shadow_bus_pkg::word_t   wdata,
    input  logic [aw-1:0]           raddr,
    output shadow_bus_pkg::word_t   q                // one cycle after raddr
);

    localparam int BW = shadow_bus_pkg::BYTE_W;
    localparam int NB = shadow_bus_pkg::NBYTES;

    shadow_bus_pkg::word_t mem [0:2**aw-1];          // no reset on contents

    // write port updates each enabled byte lane on its own
    always_ff @(posedge clk_rom) begin
        for (int i = 0; i < NB; i++) begin
            if (we[i]) begin
                mem[waddr][i*BW +: BW] <= wdata[i*BW +: BW];
            end
        end
    end

    // read port returns old data on a same cycle write to raddr
    always_ff @(posedge clk_rom) begin
        q <= mem[raddr];
    end

    // an unknown write address would smear data across the bank
    a_waddr_known: assert property (
        @(posedge clk_rom)
        (we != '0) |-> !$isunknown(waddr)
    ) else $error("shadow_bank: write with unknown address");

endmodule

/* shadow_store.sv */
/* shadow store
   four shadow banks, writes steered by region, read word picked by region */
`timescale 1ns/1ps

module shadow_store #(
    parameter int VRAM_AW = shadow_map_pkg::VRAM_AW,
    parameter int CHAR_AW = shadow_map_pkg::CHAR_AW,
    parameter int PAL_AW  = shadow_map_pkg::PAL_AW,
    parameter int OBJ_AW  = shadow_map_pkg::OBJ_AW
) (
    input  logic        clk_rom,
    input  logic        rst_n,
    shadow_wr_if.store  wr,
    shadow_rd_if.store  rd
);

    shadow_bus_pkg::mask_t   we_vram;
    shadow_bus_pkg::mask_t   we_char;
    shadow_bus_pkg::mask_t   we_pal;
    shadow_bus_pkg::mask_t   we_obj;
    shadow_bus_pkg::word_t   q_vram;
    shadow_bus_pkg::word_t   q_char;
    shadow_bus_pkg::word_t   q_pal;
    shadow_bus_pkg::word_t   q_obj;
    shadow_bus_pkg::region_e rd_region_q;            // matches bank q timing

    // only the named bank sees the mask
    assign we_vram = (wr.region == shadow_bus_pkg::region_vram)   ? wr.we : '0;
    assign we_char = (wr.region == shadow_bus_pkg::region_char)   ? wr.we : '0;
    assign we_pal  = (wr.region == shadow_bus_pkg::region_pal)    ? wr.we : '0;
    assign we_obj  = (wr.region == shadow_bus_pkg::region_objram) ? wr.we : '0;

    // addresses cut to each bank width
    shadow_bank #(.aw(VRAM_AW)) u_vram (
        .clk_rom (clk_rom),
        .we      (we_vram),
        .waddr   (wr.addr[VRAM_AW-1:0]),
        .wdata   (wr.data),
        .raddr   (rd.addr[VRAM_AW-1:0]),
        .q       (q_vram)
    );

    shadow_bank #(.aw(CHAR_AW)) u_char (
        .clk_rom (clk_rom),
        .we      (we_char),
        .waddr   (wr.addr[CHAR_AW-1:0]),
        .wdata   (wr.data),
        .raddr   (rd.addr[CHAR_AW-1:0]),
        .q       (q_char)
    );

    shadow_bank #(.aw(PAL_AW)) u_pal (
        .clk_rom (clk_rom),
        .we      (we_pal),
        .waddr   (wr.addr[PAL_AW-1:0]),
        .wdata   (wr.data),
        .raddr   (rd.addr[PAL_AW-1:0]),
        .q       (q_pal)
    );

    shadow_bank #(.aw(OBJ_AW)) u_obj (
        .clk_rom (clk_rom),
        .we      (we_obj),
        .waddr   (wr.addr[OBJ_AW-1:0]),
        .wdata   (wr.data),
        .raddr   (rd.addr[OBJ_AW-1:0]),
        .q       (q_obj)
    );

    // region travels with the bank read
    always_ff @(posedge clk_rom or negedge rst_n) begin
        if (!rst_n) begin
            rd_region_q <= shadow_bus_pkg::region_none;
        end else begin
            rd_region_q <= rd.region;
        end
    end

    always_comb begin
        case (rd_region_q)
            shadow_bus_pkg::region_vram:   rd.q = q_vram;
            shadow_bus_pkg::region_char:   rd.q = q_char;
            shadow_bus_pkg::region_pal:    rd.q = q_pal;
            shadow_bus_pkg::region_objram: rd.q = q_obj;
            default:                       rd.q = '0;      // unmapped
        endcase
    end

    // a mask arriving with no region would reach no bank and be lost
    a_no_stray_we: assert property (
        @(posedge clk_rom) disable iff (!rst_n)
        (wr.region == shadow_bus_pkg::region_none) |-> (wr.we == '0)
    ) else $error("shadow_store: write mask with no region");

endmodule

/* shadow_dump.sv */
/* shadow dump port
   decodes the byte address, reads the banks and returns one byte */
`timescale 1ns/1ps

module shadow_dump (
    input  logic                              clk_rom,
    input  logic                              rst_n,
    input  logic [shadow_map_pkg::DUMP_W-1:0] ioctl_addr,  // held level
    output logic [shadow_bus_pkg::BYTE_W-1:0] ioctl_din,   // 3 cycles later
    shadow_rd_if.dump                         rd
);

    localparam int BW = shadow_bus_pkg::BYTE_W;

    logic [shadow_map_pkg::DUMP_W-1:0] addr_q;           // stage 1
    logic [shadow_map_pkg::SEL_W-1:0]  sel;
    logic                              lo_q;             // stage 2, odd byte

    assign sel = addr_q[shadow_map_pkg::SEL_HI:shadow_map_pkg::SEL_LO];

    // region decode on bits 15..11
    always_comb begin
        if ((sel & shadow_map_pkg::VRAM_MASK) == shadow_map_pkg::VRAM_MATCH) begin
            rd.region = shadow_bus_pkg::region_vram;
        end else if ((sel & shadow_map_pkg::CHAR_MASK) == shadow_map_pkg::CHAR_MATCH) begin
            rd.region = shadow_bus_pkg::region_char;
        end else if ((sel & shadow_map_pkg::PAL_MASK) == shadow_map_pkg::PAL_MATCH) begin
            rd.region = shadow_bus_pkg::region_pal;
        end else if ((sel & shadow_map_pkg::OBJ_MASK) == shadow_map_pkg::OBJ_MATCH) begin
            rd.region = shadow_bus_pkg::region_objram;
        end else begin
            rd.region = shadow_bus_pkg::region_none;
        end
    end

    // word address, store cuts it per bank
    assign rd.addr = addr_q[shadow_map_pkg::ADDR_W:1];

    always_ff @(posedge clk_rom or negedge rst_n) begin
        if (!rst_n) begin
            addr_q    <= shadow_map_pkg::DUMP_IDLE;      // unmapped, reads zero
            lo_q      <= 1'b0;
            ioctl_din <= '0;
        end else begin
            addr_q    <= ioctl_addr;
            lo_q      <= addr_q[0];                      // lines up with rd.q
            // even address gives the high byte
            ioctl_din <= lo_q ? rd.q[BW-1:0] : rd.q[2*BW-1:BW];
        end
    end

    // unmapped reads come back as zero two cycles on, through the store
    a_none_zero: assert property (
        @(posedge clk_rom) disable iff (!rst_n)
        (rd.region == shadow_bus_pkg::region_none) |-> ##2 (ioctl_din == '0)
    ) else $error("shadow_dump: unmapped address returned nonzero byte");

endmodule

/* shadow_top.sv */
/* shadow copy top
   cpu write capture, shadow banks and byte dump port on clk_rom */
`timescale 1ns/1ps

module shadow_top #(
    parameter int VRAM_AW = shadow_map_pkg::VRAM_AW,
    parameter int CHAR_AW = shadow_map_pkg::CHAR_AW,
    parameter int PAL_AW  = shadow_map_pkg::PAL_AW,
    parameter int OBJ_AW  = shadow_map_pkg::OBJ_AW
) (
    input  logic                              clk_rom,
    input  logic                              rst_n,
    // cpu write bus
    input  logic [shadow_map_pkg::ADDR_W:1]   addr,
    input  logic                              char_cs,
    input  logic                              vram_cs,
    input  logic                              pal_cs,
    input  logic                              objram_cs,
    input  shadow_bus_pkg::word_t             din,
    input  shadow_bus_pkg::mask_t             dswn,        // active low
    // debug dump
    input  logic [shadow_map_pkg::DUMP_W-1:0] ioctl_addr,
    output logic [shadow_bus_pkg::BYTE_W-1:0] ioctl_din
);

    shadow_wr_if wr_link ();
    shadow_rd_if rd_link ();

    shadow_capture u_capture (
        .clk_rom   (clk_rom),
        .rst_n     (rst_n),
        .addr      (addr),
        .char_cs   (char_cs),
        .vram_cs   (vram_cs),
        .pal_cs    (pal_cs),
        .objram_cs (objram_cs),
        .din       (din),
        .dswn      (dswn),
        .wr        (wr_link.capture)
    );

    shadow_store #(
        .VRAM_AW (VRAM_AW),
        .CHAR_AW (CHAR_AW),
        .PAL_AW  (PAL_AW),
        .OBJ_AW  (OBJ_AW)
    ) u_store (
        .clk_rom (clk_rom),
        .rst_n   (rst_n),
        .wr      (wr_link.store),
        .rd      (rd_link.store)
    );

    shadow_dump u_dump (
        .clk_rom    (clk_rom),
        .rst_n      (rst_n),
        .ioctl_addr (ioctl_addr),
        .ioctl_din  (ioctl_din),
        .rd         (rd_link.dump)
    );

endmodule

/* tb_shadow.sv */
/* shadow copy testbench
   random cpu writes and byte dumps checked against a word model */
`timescale 1ns/1ps

module tb_shadow;

    localparam int CLK_NS    = 10;
    localparam int N_FULL    = 48;                  // full word writes
    localparam int N_PART    = 24;                  // single byte writes
    localparam int N_IDLE    = 32;                  // cycles with no chip select
    localparam int N_PIPE    = 64;                  // back to back dumps
    localparam int N_WRITES  = N_FULL + N_PART + N_IDLE + N_PIPE + 8;
    localparam int N_DUMPS   = 2*N_FULL + 2*N_PART + N_IDLE + N_PIPE + 24;
    localparam int WD_CYCLES = (N_WRITES + N_DUMPS) * 4 + 1000;

    logic                  clk_rom;
    logic                  rst_n;
    logic [14:1]           addr;
    logic                  char_cs;
    logic                  vram_cs;
    logic                  pal_cs;
    logic                  objram_cs;
    shadow_bus_pkg::word_t din;
    shadow_bus_pkg::mask_t dswn;                    // active low
    logic [15:0]           ioctl_addr;
    logic [7:0]            ioctl_din;

    // model banks with one word per bank address
    shadow_bus_pkg::word_t vram_m [0:(1 << shadow_map_pkg::VRAM_AW)-1];
    shadow_bus_pkg::word_t char_m [0:(1 << shadow_map_pkg::CHAR_AW)-1];
    shadow_bus_pkg::word_t pal_m  [0:(1 << shadow_map_pkg::PAL_AW)-1];
    shadow_bus_pkg::word_t obj_m  [0:(1 << shadow_map_pkg::OBJ_AW)-1];

    int          wr_reg[$];                         // words known to hold data
    int          wr_word[$];
    int          touched[$];                        // list indices hit by byte writes or noise
    logic [15:0] exp_addr[$];                       // dumps in flight
    logic [7:0]  exp_byte[$];
    int          exp_due[$];
    int          cycle;

    shadow_top dut_i (
        .clk_rom    (clk_rom),
        .rst_n      (rst_n),
        .addr       (addr),
        .char_cs    (char_cs),
        .vram_cs    (vram_cs),
        .pal_cs     (pal_cs),
        .objram_cs  (objram_cs),
        .din        (din),
        .dswn       (dswn),
        .ioctl_addr (ioctl_addr),
        .ioctl_din  (ioctl_din)
    );

    always #(CLK_NS/2) clk_rom = ~clk_rom;

    // region codes 0 vram 1 char 2 pal 3 objram and -1 for unmapped
    function automatic int bank_aw(int r);
        case (r)
            0:       return shadow_map_pkg::VRAM_AW;
            1:       return shadow_map_pkg::CHAR_AW;
            2:       return shadow_map_pkg::PAL_AW;
            default: return shadow_map_pkg::OBJ_AW;
        endcase
    endfunction

    function automatic shadow_bus_pkg::word_t model_word(int r, int w);
        case (r)
            0:       return vram_m[w];
            1:       return char_m[w];
            2:       return pal_m[w];
            default: return obj_m[w];
        endcase
    endfunction

    task automatic model_write(int r, logic [14:1] a, shadow_bus_pkg::word_t d,
                               shadow_bus_pkg::mask_t m);
        int w;
        shadow_bus_pkg::word_t cur;
        w = int'(a) & ((1 << bank_aw(r)) - 1);      // bank keeps the low bits
        cur = model_word(r, w);
        if (m[1]) cur[15:8] = d[15:8];              // high byte lane
        if (m[0]) cur[7:0] = d[7:0];
        case (r)
            0:       vram_m[w] = cur;
            1:       char_m[w] = cur;
            2:       pal_m[w] = cur;
            default: obj_m[w] = cur;
        endcase
    endtask

    // byte address of a bank word in the 64 KB dump map
    function automatic logic [15:0] dump_addr(int r, int w, bit lo);
        logic [15:0] base;
        case (r)
            0:       base = 16'h0000;
            1:       base = 16'h8000;
            2:       base = 16'h9000;
            default: base = 16'ha000;
        endcase
        return base | 16'(w << 1) | 16'(lo);
    endfunction

    function automatic logic [7:0] expect_byte(logic [15:0] a);
        int r;
        int w;
        shadow_bus_pkg::word_t q;
        if (!a[15]) r = 0;
        else if (a[15:12] == 4'b1000) r = 1;
        else if (a[15:12] == 4'b1001) r = 2;
        else if (a[15:11] == 5'b10100) r = 3;
        else return 8'h00;                          // hole in the map
        w = int'(a[14:1]) & ((1 << bank_aw(r)) - 1);
        q = model_word(r, w);
        return a[0] ? q[7:0] : q[15:8];             // even gives high byte
    endfunction

    function automatic bit listed(int r, int w);
        foreach (wr_reg[i]) begin
            if (wr_reg[i] == r && wr_word[i] == w) return 1'b1;
        end
        return 1'b0;
    endfunction

    task automatic abort_run(string why);
        $display("%s", why);
        $display("=== FAIL ===");
        $fatal(1, "run stopped");
    endtask

    // one clock, then compare every dump that is due now
    task automatic step();
        @(posedge clk_rom);
        #1;
        cycle++;
        while (exp_due.size() > 0 && exp_due[0] == cycle) begin
            assert (ioctl_din === exp_byte[0]) else
                abort_run($sformatf("MISMATCH ioctl_din addr %h expected %h actual %h",
                                    exp_addr[0], exp_byte[0], ioctl_din));
            void'(exp_addr.pop_front());
            void'(exp_byte.pop_front());
            void'(exp_due.pop_front());
        end
    endtask

    task automatic set_dump(logic [15:0] a);
        ioctl_addr = a;
        exp_addr.push_back(a);
        exp_byte.push_back(expect_byte(a));         // model state at issue time
        exp_due.push_back(cycle + 3);               // three register stages
    endtask

    task automatic dump_check(logic [15:0] a);
        set_dump(a);
        repeat (3) step();
    endtask

    task automatic drive_write(int r, logic [14:1] a, shadow_bus_pkg::word_t d,
                               shadow_bus_pkg::mask_t n);
        addr = a;
        din = d;
        dswn = n;
        vram_cs = (r == 0);
        char_cs = (r == 1);
        pal_cs = (r == 2);
        objram_cs = (r == 3);
        if (r >= 0) model_write(r, a, d, ~n);       // model applies it at once
    endtask

    task automatic settle(int n);
        drive_write(-1, addr, din, 2'b11);
        repeat (n) step();
    endtask

    initial begin
        #(WD_CYCLES * CLK_NS);
        abort_run("timeout: the test sequence did not finish in the expected time");
    end

    initial begin
        int r;
        int w;
        int k;
        logic [14:1] a;
        void'($urandom(32'h521b));
        clk_rom = 1'b0;
        rst_n = 1'b0;
        ioctl_addr = 16'hffff;
        cycle = 0;
        drive_write(-1, '0, '0, 2'b11);
        repeat (8) @(posedge clk_rom);
        #1;
        rst_n = 1'b1;

        // reset state and holes in the map
        assert (ioctl_din === 8'h00) else
            abort_run($sformatf("MISMATCH ioctl_din after reset expected %h actual %h",
                                8'h00, ioctl_din));
        dump_check(16'ha800);                       // 10101
        dump_check(16'hafff);
        dump_check(16'hc000);                       // 11xxx
        dump_check(16'hfffe);

        // full words to all regions with random upper address bits
        for (int i = 0; i < N_FULL; i++) begin
            r = i % 4;
            a = 14'($urandom());
            drive_write(r, a, 16'($urandom()), 2'b00);
            wr_reg.push_back(r);
            wr_word.push_back(int'(a) & ((1 << bank_aw(r)) - 1));
            step();
        end
        settle(2);
        foreach (wr_reg[i]) begin
            dump_check(dump_addr(wr_reg[i], wr_word[i], 1'b0));
            dump_check(dump_addr(wr_reg[i], wr_word[i], 1'b1));
        end

        // single byte writes over known words
        for (int i = 0; i < N_PART; i++) begin
            k = $urandom_range(wr_reg.size() - 1);
            drive_write(wr_reg[k], 14'(wr_word[k]), 16'($urandom()),
                        ($urandom() & 1) ? 2'b01 : 2'b10);
            touched.push_back(k);
            step();
        end
        settle(2);
        foreach (touched[i]) begin
            dump_check(dump_addr(wr_reg[touched[i]], wr_word[touched[i]], 1'b0));
            dump_check(dump_addr(wr_reg[touched[i]], wr_word[touched[i]], 1'b1));
        end

        // bus noise on known words with no chip select leaves the model alone
        touched.delete();
        for (int i = 0; i < N_IDLE; i++) begin
            k = $urandom_range(wr_reg.size() - 1);
            touched.push_back(k);
            drive_write(-1, 14'(wr_word[k]), 16'($urandom()), 2'($urandom_range(2)));
            step();
        end
        settle(2);
        foreach (touched[i]) begin
            dump_check(dump_addr(wr_reg[touched[i]], wr_word[touched[i]], 1'($urandom())));
        end

        // new dump address every cycle while writes go to words never dumped
        for (int i = 0; i < N_PIPE; i++) begin
            k = $urandom_range(wr_reg.size() - 1);
            set_dump(dump_addr(wr_reg[k], wr_word[k], 1'($urandom())));
            r = $urandom_range(3);
            do begin
                a = 14'($urandom());
                w = int'(a) & ((1 << bank_aw(r)) - 1);
            end while (listed(r, w));
            drive_write(r, a, 16'($urandom()), 2'($urandom()));
            step();
        end
        settle(3);                                  // drain the last reads

        // top and bottom word of each bank with address bits above the bank set
        for (int i = 0; i < 4; i++) begin
            drive_write(i, 14'h3fff, 16'($urandom()), 2'b00);
            step();
            a = 14'h3fff & ~14'((1 << bank_aw(i)) - 1);
            drive_write(i, a, 16'($urandom()), 2'b00);
            step();
        end
        settle(2);
        for (int i = 0; i < 4; i++) begin
            w = (1 << bank_aw(i)) - 1;
            dump_check(dump_addr(i, w, 1'b0));
            dump_check(dump_addr(i, w, 1'b1));      // last byte of the region
            dump_check(dump_addr(i, 0, 1'b0));
            dump_check(dump_addr(i, 0, 1'b1));
        end
        dump_check(16'ha800);                       // just past objram
        dump_check(16'hb000);
        dump_check(16'hbffe);
        dump_check(16'hffff);

        $display("=== PASS ===");
        $finish;
    end

endmodule

/* vlog.f */
shadow_map_pkg.sv
shadow_bus_pkg.sv
shadow_if.sv
shadow_capture.sv
shadow_bank.sv
shadow_store.sv
shadow_dump.sv
shadow_top.sv
tb_shadow.sv
